// File: include/joypad_macros.svh
// ============================
// joypad macros
// register map, autofire timing and
// NES button count for the controller path
// ============================

`ifndef JOYPAD_MACROS_SVH
`define JOYPAD_MACROS_SVH

// host override registers on the register bus
// player 2 sits one address above player 1
`define JOY_ADDR_BTN1 8'h40

// autofire half period in clk cycles
// kept short so the waveform is quick to observe in simulation
`define JOY_AUTOFIRE_HALF 4

// NES standard controller has 8 buttons
// order R L D U START SELECT B A, A in bit 0
`define JOY_NUM_BUTTONS 8

`endif

// File: source/joypad_pkg.sv
// ============================
// joypad package
// vector types shared by the controller path
// ============================

`include "joypad_macros.svh"

package joypad_pkg;

  // NES button byte, active high
  // bit 7..0 = R L D U START SELECT B A
  typedef logic [`JOY_NUM_BUTTONS-1:0] nes_buttons_t;

  // one Dualshock receive byte, active low as it comes off the pad
  typedef logic [7:0] ds_byte_t;

  // register bus fields
  typedef logic [7:0] reg_addr_t;
  typedef logic [7:0] reg_data_t;

endpackage

// File: source/host_button_regs.sv
// ============================
// host button registers
// decodes register bus writes into the
// two host override button bytes
// ============================

`timescale 1ns/1ps

`include "joypad_macros.svh"

module host_button_regs (
  input  logic                   clk,
  input  logic                   sys_resetn,
  input  joypad_pkg::reg_addr_t  reg_addr,
  input  joypad_pkg::reg_data_t  reg_data,
  input  logic                   reg_write,
  output joypad_pkg::nes_buttons_t host_btn1,
  output joypad_pkg::nes_buttons_t host_btn2
);

  logic hit_btn1;
  logic hit_btn2;

  // address decode, anything else on the bus is for some other block
  assign hit_btn1 = reg_write && (reg_addr == joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1));
  assign hit_btn2 = reg_write && (reg_addr == joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1 + 1));

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      host_btn1 <= '0;
      host_btn2 <= '0;
    end else begin
      if (hit_btn1) begin
        host_btn1 <= joypad_pkg::nes_buttons_t'(reg_data);
      end
      if (hit_btn2) begin
        host_btn2 <= joypad_pkg::nes_buttons_t'(reg_data);
      end
    end
  end

  // a write strobe must come with a clean address, else a stray
  // X could land in either button byte and reach the console
  a_write_addr_known: assert property (
    @(posedge clk) disable iff (!sys_resetn)
    reg_write |-> !$isunknown(reg_addr)
  ) else $error("register write with unknown address");

endmodule

// File: source/autofire.sv
// ============================
// autofire
// turns a held button into a square
// wave of fixed half period
// ============================

`timescale 1ns/1ps

`include "joypad_macros.svh"

module autofire (
  input  logic clk,
  input  logic sys_resetn,
  input  logic btn,
  output logic fire
);

  localparam int CNT_W = (2 * `JOY_AUTOFIRE_HALF > 1) ? $clog2(2 * `JOY_AUTOFIRE_HALF) : 1;

  logic [CNT_W-1:0] cnt;
  logic             cnt_wrap;

  // last count of a full on/off period
  assign cnt_wrap = (cnt == CNT_W'(2 * `JOY_AUTOFIRE_HALF - 1));

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      cnt  <= '0;
      fire <= 1'b0;
    end else if (!btn) begin
      // released, restart so the next press fires at once
      cnt  <= '0;
      fire <= 1'b0;
    end else begin
      cnt  <= cnt_wrap ? '0 : cnt + 1'b1;
      fire <= (cnt < CNT_W'(`JOY_AUTOFIRE_HALF)); // first half of period
    end
  end

  // a release must drop the output on the very next cycle
  a_release_stops_fire: assert property (
    @(posedge clk) disable iff (!sys_resetn)
    !btn |=> !fire
  ) else $error("autofire still high after button release");

endmodule

// File: source/dualshock_mapper.sv
// ============================
// dualshock mapper
// maps one pad's first two receive bytes
// onto NES button order, with autofire
// ============================

`timescale 1ns/1ps

module dualshock_mapper (
  input  logic                     clk,
  input  logic                     sys_resetn,
  input  joypad_pkg::ds_byte_t     rx0,
  input  joypad_pkg::ds_byte_t     rx1,
  output joypad_pkg::nes_buttons_t pad_btn
);

  // rx0 layout, bit 7..0 = L D R U START R3 L3 SELECT
  localparam int RX0_LEFT   = 7;
  localparam int RX0_DOWN   = 6;
  localparam int RX0_RIGHT  = 5;
  localparam int RX0_UP     = 4;
  localparam int RX0_START  = 3;
  localparam int RX0_SELECT = 0;

  // rx1 layout, bit 7..0 = square X O triangle R1 L1 R2 L2
  localparam int RX1_SQUARE   = 7;
  localparam int RX1_CROSS    = 6;
  localparam int RX1_CIRCLE   = 5;
  localparam int RX1_TRIANGLE = 4;

  logic square_fire;
  logic triangle_fire;

  // square repeats B
  autofire u_af_square (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .btn        (~rx1[RX1_SQUARE]),
    .fire       (square_fire)
  );

  // triangle repeats A
  autofire u_af_triangle (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .btn        (~rx1[RX1_TRIANGLE]),
    .fire       (triangle_fire)
  );

  // pad bits are active low, NES bits active high
  // direct buttons stay combinational so the shifter sees them this cycle
  assign pad_btn = {
    ~rx0[RX0_RIGHT],
    ~rx0[RX0_LEFT],
    ~rx0[RX0_DOWN],
    ~rx0[RX0_UP],
    ~rx0[RX0_START],
    ~rx0[RX0_SELECT],
    ~rx1[RX1_CROSS]  | square_fire,     // B
    ~rx1[RX1_CIRCLE] | triangle_fire    // A
  };

endmodule

// File: source/joypad_shifter.sv
// ============================
// joypad shifter
// NES controller port, latches buttons on
// strobe and shifts them out serially
// ============================

`timescale 1ns/1ps

module joypad_shifter (
  input  logic                     clk,
  input  logic                     sys_resetn,
  input  joypad_pkg::nes_buttons_t host_btn1,
  input  joypad_pkg::nes_buttons_t host_btn2,
  input  joypad_pkg::nes_buttons_t pad_btn1,
  input  joypad_pkg::nes_buttons_t pad_btn2,
  input  logic                     joypad_strobe,
  input  logic [1:0]               joypad_clock,
  output logic [1:0]               joypad_data
);

  localparam int NUM_PLAYERS = 2;

  joypad_pkg::nes_buttons_t bits_q   [NUM_PLAYERS]; // one shift register per player
  joypad_pkg::nes_buttons_t load_val [NUM_PLAYERS];
  logic [NUM_PLAYERS-1:0]   prev_clock;
  logic [NUM_PLAYERS-1:0]   clock_fall;

  // host overrides and pad buttons merge here
  assign load_val[0] = host_btn1 | pad_btn1;
  assign load_val[1] = host_btn2 | pad_btn2;

  // falling edge of each player's joypad clock against last cycle
  assign clock_fall = prev_clock & ~joypad_clock;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      prev_clock <= '0;
      for (int p = 0; p < NUM_PLAYERS; p++) begin
        bits_q[p] <= '0;
      end
    end else begin
      prev_clock <= joypad_clock;
      for (int p = 0; p < NUM_PLAYERS; p++) begin
        if (clock_fall[p]) begin
          // shift wins over a strobe in the same cycle
          bits_q[p] <= bits_q[p] >> 1; // zero enters at the top
        end else if (joypad_strobe) begin
          bits_q[p] <= load_val[p];
        end
      end
    end
  end

  // serial out is the low bit, A comes first after a latch
  assign joypad_data = {bits_q[1][0], bits_q[0][0]};

  // the console reads these pins at any time, they must never float
  a_data_known: assert property (
    @(posedge clk) disable iff (!sys_resetn)
    !$isunknown(joypad_data)
  ) else $error("joypad_data has unknown bits");

endmodule

// File: source/joypad_top.sv
// ============================
// joypad top
// controller path of the NES board, host
// registers and two pads into the joypad port
// ============================

`timescale 1ns/1ps

module joypad_top (
  input  logic                  clk,
  input  logic                  sys_resetn,

  // register bus from the host UART
  input  joypad_pkg::reg_addr_t reg_addr,
  input  joypad_pkg::reg_data_t reg_data,
  input  logic                  reg_write,

  // Dualshock receive bytes, active low
  input  joypad_pkg::ds_byte_t  pad1_rx0,
  input  joypad_pkg::ds_byte_t  pad1_rx1,
  input  joypad_pkg::ds_byte_t  pad2_rx0,
  input  joypad_pkg::ds_byte_t  pad2_rx1,

  // NES joypad port
  input  logic                  joypad_strobe,
  input  logic [1:0]            joypad_clock,  // one per player
  output logic [1:0]            joypad_data
);

  joypad_pkg::nes_buttons_t host_btn1;
  joypad_pkg::nes_buttons_t host_btn2;
  joypad_pkg::nes_buttons_t pad_btn1;
  joypad_pkg::nes_buttons_t pad_btn2;

  host_button_regs u_host_regs (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .reg_addr   (reg_addr),
    .reg_data   (reg_data),
    .reg_write  (reg_write),
    .host_btn1  (host_btn1),
    .host_btn2  (host_btn2)
  );

  dualshock_mapper u_pad1 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .rx0        (pad1_rx0),
    .rx1        (pad1_rx1),
    .pad_btn    (pad_btn1)
  );

  dualshock_mapper u_pad2 (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .rx0        (pad2_rx0),
    .rx1        (pad2_rx1),
    .pad_btn    (pad_btn2)
  );

  joypad_shifter u_shifter (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .host_btn1     (host_btn1),
    .host_btn2     (host_btn2),
    .pad_btn1      (pad_btn1),
    .pad_btn2      (pad_btn2),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock),
    .joypad_data   (joypad_data)
  );

endmodule

// File: verification/tb_joypad_top.sv
// ==============================
// joypad top testbench
// random host writes and pad bytes against
// a cycle model of the controller path
// ==============================

`timescale 1ns/1ps

`include "joypad_macros.svh"

module tb_joypad_top;

  localparam int CLK_PERIOD  = 40;
  localparam int N_HOST      = 12;
  localparam int N_PAD       = 12;
  localparam int N_MIX       = 8;
  localparam int N_EDGE      = 6;
  localparam int HOLD        = 10 * `JOY_AUTOFIRE_HALF;
  localparam int READ_CYCLES = 3 * `JOY_NUM_BUTTONS + 2;
  localparam int TEST_CYCLES = 16 + (N_HOST + N_PAD) * (10 + 2 * READ_CYCLES)
                             + N_MIX * (12 + 2 * (READ_CYCLES + 8))
                             + 2 * (HOLD + 16) + N_EDGE * (18 + 2 * READ_CYCLES);

  logic                     clk = 1'b0;
  logic                     sys_resetn;
  joypad_pkg::reg_addr_t    reg_addr;
  joypad_pkg::reg_data_t    reg_data;
  logic                     reg_write;
  joypad_pkg::ds_byte_t     pad1_rx0;
  joypad_pkg::ds_byte_t     pad1_rx1;
  joypad_pkg::ds_byte_t     pad2_rx0;
  joypad_pkg::ds_byte_t     pad2_rx1;
  logic                     joypad_strobe;
  logic [1:0]               joypad_clock;
  logic [1:0]               joypad_data;

  // reference model state
  joypad_pkg::nes_buttons_t m_host [2];
  joypad_pkg::nes_buttons_t m_sh   [2];
  joypad_pkg::nes_buttons_t m_load [2];
  logic [1:0]               m_prev;
  logic [1:0]               m_fall;
  int                       m_af_cnt  [4]; // pad1 square, pad1 triangle, pad2 ...
  logic                     m_af_fire [4];

  logic [31:0] lfsr_state = 32'he8a6_b96b;
  int          test_errs;
  int          tests_passed;
  int          tests_failed;

  joypad_top DUT (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .reg_addr      (reg_addr),
    .reg_data      (reg_data),
    .reg_write     (reg_write),
    .pad1_rx0      (pad1_rx0),
    .pad1_rx1      (pad1_rx1),
    .pad2_rx0      (pad2_rx0),
    .pad2_rx1      (pad2_rx1),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock),
    .joypad_data   (joypad_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // taps 32 22 2 1
  function logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function logic [7:0] rand_byte();
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < 8; i++) v = {v[6:0], lfsr_step()};
    return v;
  endfunction

  // pad bits are active low, NES order R L D U START SELECT B A
  function joypad_pkg::nes_buttons_t map_pad(input joypad_pkg::ds_byte_t rx0,
                                             input joypad_pkg::ds_byte_t rx1,
                                             input logic sq_fire, input logic tri_fire);
    joypad_pkg::nes_buttons_t b;
    b[7] = ~rx0[5];
    b[6] = ~rx0[7];
    b[5] = ~rx0[6];
    b[4] = ~rx0[4];
    b[3] = ~rx0[3];
    b[2] = ~rx0[0];
    b[1] = ~rx1[6] | sq_fire;
    b[0] = ~rx1[5] | tri_fire;
    return b;
  endfunction

  task automatic step_autofire(input int idx, input logic btn);
    if (!btn) begin
      m_af_cnt[idx]  = 0;
      m_af_fire[idx] = 1'b0;
    end else begin
      m_af_fire[idx] = (m_af_cnt[idx] < `JOY_AUTOFIRE_HALF);
      m_af_cnt[idx]  = (m_af_cnt[idx] == 2 * `JOY_AUTOFIRE_HALF - 1) ? 0 : m_af_cnt[idx] + 1;
    end
  endtask

  // model sees the same pre-edge inputs as the DUT
  always @(posedge clk) begin
    if (!sys_resetn) begin
      m_prev = '0;
      for (int i = 0; i < 2; i++) begin
        m_host[i] = '0;
        m_sh[i]   = '0;
      end
      for (int i = 0; i < 4; i++) begin
        m_af_cnt[i]  = 0;
        m_af_fire[i] = 1'b0;
      end
    end else begin
      m_load[0] = m_host[0] | map_pad(pad1_rx0, pad1_rx1, m_af_fire[0], m_af_fire[1]);
      m_load[1] = m_host[1] | map_pad(pad2_rx0, pad2_rx1, m_af_fire[2], m_af_fire[3]);
      m_fall    = m_prev & ~joypad_clock;
      for (int i = 0; i < 2; i++) begin
        if (m_fall[i]) m_sh[i] = m_sh[i] >> 1;
        else if (joypad_strobe) m_sh[i] = m_load[i];
      end
      m_prev = joypad_clock;
      if (reg_write && reg_addr == joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1)) begin
        m_host[0] = reg_data;
      end else if (reg_write && reg_addr == joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1 + 1)) begin
        m_host[1] = reg_data;
      end
      step_autofire(0, ~pad1_rx1[7]);
      step_autofire(1, ~pad1_rx1[4]);
      step_autofire(2, ~pad2_rx1[7]);
      step_autofire(3, ~pad2_rx1[4]);
    end
  end

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic host_write(input joypad_pkg::reg_addr_t addr, input joypad_pkg::reg_data_t data);
    @(posedge clk);
    reg_addr  <= addr;
    reg_data  <= data;
    reg_write <= 1'b1;
    @(posedge clk);
    reg_write <= 1'b0;
  endtask

  task automatic set_pads(input joypad_pkg::ds_byte_t a0, input joypad_pkg::ds_byte_t a1,
                          input joypad_pkg::ds_byte_t b0, input joypad_pkg::ds_byte_t b1);
    @(posedge clk);
    pad1_rx0 <= a0;
    pad1_rx1 <= a1;
    pad2_rx0 <= b0;
    pad2_rx1 <= b1;
  endtask

  task automatic latch_buttons();
    @(posedge clk);
    joypad_strobe <= 1'b1;
    @(posedge clk);
    joypad_strobe <= 1'b0;
    @(negedge clk);
  endtask

  task automatic pulse_clock(input int p);
    @(posedge clk);
    joypad_clock[p] <= 1'b1;
    @(posedge clk);
    joypad_clock[p] <= 1'b0;
    @(posedge clk);
    @(negedge clk);
  endtask

  // 8 serial reads, A first
  task automatic check_buttons(input string name, input int p,
                               input joypad_pkg::nes_buttons_t exp);
    joypad_pkg::nes_buttons_t got;
    got = '0;
    for (int i = 0; i < `JOY_NUM_BUTTONS; i++) begin
      got[i] = joypad_data[p];
      check_bit(name, m_sh[p][0], joypad_data[p]);
      pulse_clock(p);
    end
    if (got !== exp) begin
      $display("[FAIL] %s: player %0d expected %h, actual %h", name, p + 1, exp, got);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d mismatches", name, test_errs);
    end
    test_errs = 0;
  endtask

  initial begin
    #(TEST_CYCLES * CLK_PERIOD + 50 * CLK_PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    joypad_pkg::nes_buttons_t h [2];
    joypad_pkg::nes_buttons_t h_new [2];
    joypad_pkg::ds_byte_t     r [4];
    joypad_pkg::reg_addr_t    addr;
    joypad_pkg::reg_data_t    data;
    int                       p;
    int                       rises;
    int                       last_rise;
    logic                     last_bit;

    sys_resetn    = 1'b0;
    reg_addr      = '0;
    reg_data      = '0;
    reg_write     = 1'b0;
    pad1_rx0      = 8'hff;
    pad1_rx1      = 8'hff;
    pad2_rx0      = 8'hff;
    pad2_rx1      = 8'hff;
    joypad_strobe = 1'b0;
    joypad_clock  = 2'b00;
    test_errs     = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    h[0] = '0;
    h[1] = '0;
    repeat (3) @(posedge clk);
    sys_resetn <= 1'b1;

    // reset state, nothing latched
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      check_bit("reset", 1'b0, joypad_data[0]);
      check_bit("reset", 1'b0, joypad_data[1]);
    end
    finish_test("reset");

    for (int n = 0; n < N_HOST; n++) begin
      for (int w = 0; w < 3; w++) begin
        p    = int'(lfsr_step()) * 2 + int'(lfsr_step());
        data = rand_byte();
        addr = rand_byte();
        if (p < 2) addr = joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1 + p);
        else if (addr[7:1] == 7'h20) addr = addr ^ 8'h10; // keep off both player addresses
        if (p < 2) h[p] = data;
        host_write(addr, data);
      end
      latch_buttons();
      check_buttons("host_regs", 0, h[0]);
      check_buttons("host_regs", 1, h[1]);
    end
    finish_test("host_regs");

    host_write(joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1), 8'h00);
    host_write(joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1 + 1), 8'h00);
    for (int n = 0; n < N_PAD; n++) begin
      for (int i = 0; i < 4; i++) r[i] = rand_byte();
      r[1] = r[1] | 8'h90;  // square and triangle released
      r[3] = r[3] | 8'h90;
      set_pads(r[0], r[1], r[2], r[3]);
      latch_buttons();
      check_buttons("pad_map", 0, map_pad(r[0], r[1], 1'b0, 1'b0));
      check_buttons("pad_map", 1, map_pad(r[2], r[3], 1'b0, 1'b0));
    end
    finish_test("pad_map");

    for (int n = 0; n < N_MIX; n++) begin
      h[0] = rand_byte();
      h[1] = rand_byte();
      for (int i = 0; i < 4; i++) r[i] = rand_byte();
      r[1] = r[1] | 8'h90;
      r[3] = r[3] | 8'h90;
      host_write(joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1), h[0]);
      host_write(joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1 + 1), h[1]);
      set_pads(r[0], r[1], r[2], r[3]);
      latch_buttons();
      for (int q = 0; q < 2; q++) begin
        check_buttons("host_or_pad", q, h[q] | map_pad(r[2*q], r[2*q+1], 1'b0, 1'b0));
        check_bit("host_or_pad", 1'b0, joypad_data[q]); // ninth read
        pulse_clock(q);
        check_bit("host_or_pad", 1'b0, joypad_data[q]); // tenth read
      end
    end
    finish_test("host_or_pad");

    host_write(joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1), 8'h00);
    host_write(joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1 + 1), 8'h00);
    for (int q = 0; q < 2; q++) begin
      set_pads(8'hff, 8'hff, 8'hff, 8'hff);
      @(posedge clk);
      joypad_strobe <= 1'b1;
      if (q == 0) pad1_rx1 <= 8'hef;  // triangle held
      else pad2_rx1 <= 8'hef;
      @(negedge clk);
      last_bit  = joypad_data[q];
      rises     = 0;
      last_rise = 0;
      for (int c = 0; c < HOLD; c++) begin
        @(negedge clk);
        check_bit("autofire", m_sh[q][0], joypad_data[q]);
        check_bit("autofire", m_sh[1-q][0], joypad_data[1-q]);
        if (joypad_data[q] && !last_bit) begin
          if (rises > 0 && c - last_rise != 2 * `JOY_AUTOFIRE_HALF) begin
            $display("[FAIL] autofire: expected period %0d, actual %0d",
                     2 * `JOY_AUTOFIRE_HALF, c - last_rise);
            test_errs++;
          end
          last_rise = c;
          rises++;
        end
        last_bit = joypad_data[q];
      end
      if (rises < 2) begin
        $display("autofire on player %0d did not toggle while triangle was held", q + 1);
        test_errs++;
      end
      @(posedge clk);
      joypad_strobe <= 1'b0;
    end
    set_pads(8'hff, 8'hff, 8'hff, 8'hff);
    finish_test("autofire");

    for (int n = 0; n < N_EDGE; n++) begin
      h[0]     = rand_byte();
      h[1]     = rand_byte();
      h_new[0] = rand_byte();
      h_new[1] = rand_byte();
      p        = int'(lfsr_step());
      host_write(joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1), h[0]);
      host_write(joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1 + 1), h[1]);
      latch_buttons();
      host_write(joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1), h_new[0]);
      host_write(joypad_pkg::reg_addr_t'(`JOY_ADDR_BTN1 + 1), h_new[1]);
      @(posedge clk);
      joypad_clock[p] <= 1'b1;
      @(posedge clk);
      joypad_clock[p] <= 1'b0;  // falls with the strobe
      joypad_strobe   <= 1'b1;
      @(posedge clk);
      joypad_strobe   <= 1'b0;
      @(negedge clk);
      check_buttons("strobe_vs_shift", p, h[p] >> 1);
      check_buttons("strobe_vs_shift", 1 - p, h_new[1-p]);
    end
    finish_test("strobe_vs_shift");

    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+include
source/joypad_pkg.sv
source/host_button_regs.sv
source/autofire.sv
source/dualshock_mapper.sv
source/joypad_shifter.sv
source/joypad_top.sv
verification/tb_joypad_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the joypad testbench with Verilator.
# Exit status is nonzero unless the log holds the pass message.

set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_joypad_top \
  --Mdir "$BUILD_DIR" \
  -o tb_joypad_top_sim

"./$BUILD_DIR/tb_joypad_top_sim" | tee "$LOG"

if grep -q "TEST PASSED" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed, see $LOG"
  exit 1
fi
